//--- Makefile
TOP := tb_stream_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

//--- filelist.f
stream_pkg.sv
wb_regs_pkg.sv
sync_fifo.sv
mem_to_handshake_fifo.sv
stream_lane.sv
wb_lane_config.sv
lane_merger.sv
stream_top.sv
tb_stream_top.sv

//--- lane_merger.sv
// Lane stream merger
`default_nettype none

module lane_merger import stream_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // Lane side
    input  logic [NUM_LANES-1:0] lane_valid_i,
    input  merged_data_t         lane_data_i,
    output logic [NUM_LANES-1:0] lane_ready_o,
    // Merged output
    output logic                 out_valid_o,
    output merged_data_t         out_data_o,
    input  logic                 out_ready_i
);

    logic         out_valid_q;
    merged_data_t out_data_q;
    logic         load;

    // Take a word when every lane has one and the stage is free or draining
    assign load = (&lane_valid_i) & (~out_valid_q | out_ready_i);

    // All lanes pop in the same cycle
    assign lane_ready_o = {NUM_LANES{load}};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (load) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data_q <= lane_data_i;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

endmodule

`default_nettype wire

//--- mem_to_handshake_fifo.sv
// Memory reader with handshake buffer
`default_nettype none

module mem_to_handshake_fifo import stream_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       en_i,
    input  logic       flush_i,
    // Last address read before wrapping, inclusive
    input  mem_addr_t  addr_upper_bound_i,
    // Memory read port
    output logic       mem_ren_o,
    output mem_addr_t  mem_raddr_o,
    input  logic       mem_rdata_valid_i,
    input  lane_data_t mem_rdata_i,
    // Downstream handshake
    input  logic       data_ready_i,
    output logic       data_valid_o,
    output lane_data_t data_o
);

    mem_addr_t raddr_q;
    mem_addr_t raddr_n;

    logic fifo_empty;
    logic fifo_almost_full;
    logic fifo_pop;

    // Stop reading once the buffer can only take the read in flight
    assign mem_ren_o   = en_i & ~fifo_almost_full & ~flush_i;
    assign mem_raddr_o = raddr_q;

    // Wrap to zero after the bound
    assign raddr_n = (raddr_q == addr_upper_bound_i) ? '0 : mem_addr_t'(raddr_q + 1'b1);

    // Data is only offered while enabled
    assign data_valid_o = en_i & ~fifo_empty;
    assign fifo_pop     = data_valid_o & data_ready_i;

    // Read address advances on every issued read
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            raddr_q <= '0;
        end else if (mem_ren_o) begin
            raddr_q <= raddr_n;
        end
    end

    // Read data buffer, flush wins over a late push
    sync_fifo data_fifo_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .push_i        (mem_rdata_valid_i),
        .data_i        (mem_rdata_i),
        .pop_i         (fifo_pop),
        .data_o        (data_o),
        .full_o        (),
        .empty_o       (fifo_empty),
        .almost_full_o (fifo_almost_full),
        .usage_o       ()
    );

endmodule

`default_nettype wire

//--- stream_lane.sv
// Single operand lane
`default_nettype none

module stream_lane import stream_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       en_i,
    input  logic       flush_i,
    input  mem_addr_t  bound_i,
    // Host write port
    input  logic       mem_we_i,
    input  mem_addr_t  mem_waddr_i,
    input  lane_data_t mem_wdata_i,
    // Lane stream
    input  logic       lane_ready_i,
    output logic       lane_valid_o,
    output lane_data_t lane_data_o
);

    // Word memory, contents survive reset
    lane_data_t mem_q [MEM_DEPTH];
    lane_data_t rdata_q;
    logic       rvalid_q;

    logic      mem_ren;
    mem_addr_t mem_raddr;

    // Host write and registered read share the clock edge
    always_ff @(posedge clk_i) begin
        if (mem_we_i) begin
            mem_q[mem_waddr_i] <= mem_wdata_i;
        end
        if (mem_ren) begin
            rdata_q <= mem_q[mem_raddr];
        end
    end

    // Valid trails the read enable by one cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_ren;
        end
    end

    mem_to_handshake_fifo reader_i (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .en_i               (en_i),
        .flush_i            (flush_i),
        .addr_upper_bound_i (bound_i),
        .mem_ren_o          (mem_ren),
        .mem_raddr_o        (mem_raddr),
        .mem_rdata_valid_i  (rvalid_q),
        .mem_rdata_i        (rdata_q),
        .data_ready_i       (lane_ready_i),
        .data_valid_o       (lane_valid_o),
        .data_o             (lane_data_o)
    );

endmodule

`default_nettype wire

//--- stream_pkg.sv
// Operand streamer datapath sizes
`default_nettype none

package stream_pkg;

    // Lane organisation
    localparam int NUM_LANES   = 4;
    localparam int LANE_DATA_W = 16;
    localparam int LANE_SEL_W  = $clog2(NUM_LANES);

    // Per-lane word memory
    localparam int MEM_DEPTH  = 16;
    localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);

    // Per-lane read buffer, depth kept a power of two so pointers wrap freely
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    // Usage must be able to hold FIFO_DEPTH itself
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Merged output word, lane 0 in the low bits
    localparam int MERGED_W = NUM_LANES * LANE_DATA_W;

    typedef logic [LANE_DATA_W-1:0] lane_data_t;
    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [MERGED_W-1:0]    merged_data_t;
    typedef logic [FIFO_CNT_W-1:0]  fifo_cnt_t;
    typedef logic [FIFO_PTR_W-1:0]  fifo_ptr_t;
    typedef logic [LANE_SEL_W-1:0]  lane_sel_t;

endpackage

`default_nettype wire

//--- stream_top.sv
// Multi-lane operand streamer top
`default_nettype none

module stream_top import stream_pkg::*; import wb_regs_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    // Wishbone classic slave
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  wb_addr_t            wb_adr_i,
    input  wb_data_t            wb_dat_i,
    input  logic [WB_SEL_W-1:0] wb_sel_i,
    output wb_data_t            wb_dat_o,
    output logic                wb_ack_o,
    // Merged operand stream
    output logic                out_valid_o,
    output merged_data_t        out_data_o,
    input  logic                out_ready_i
);

    // Config to lanes
    logic       stream_en;
    logic       flush;
    mem_addr_t  bound;
    logic       mem_we;
    lane_sel_t  mem_lane;
    mem_addr_t  mem_waddr;
    lane_data_t mem_wdata;

    // Lanes to merger
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_ready;
    merged_data_t         lane_data;

    wb_lane_config config_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .stream_en_o (stream_en),
        .flush_o     (flush),
        .bound_o     (bound),
        .mem_we_o    (mem_we),
        .mem_lane_o  (mem_lane),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata)
    );

    // One lane per slice of the merged word, write strobe decoded by index
    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
        stream_lane lane_i (
            .clk_i        (clk_i),
            .reset_i      (reset_i),
            .en_i         (stream_en),
            .flush_i      (flush),
            .bound_i      (bound),
            .mem_we_i     (mem_we && (mem_lane == lane_sel_t'(g))),
            .mem_waddr_i  (mem_waddr),
            .mem_wdata_i  (mem_wdata),
            .lane_ready_i (lane_ready[g]),
            .lane_valid_o (lane_valid[g]),
            .lane_data_o  (lane_data[g*LANE_DATA_W +: LANE_DATA_W])
        );
    end

    lane_merger merger_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .lane_valid_i (lane_valid),
        .lane_data_i  (lane_data),
        .lane_ready_o (lane_ready),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

`default_nettype wire

//--- sync_fifo.sv
// Synchronous lane FIFO
`default_nettype none

module sync_fifo import stream_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       flush_i,
    // Write side
    input  logic       push_i,
    input  lane_data_t data_i,
    // Read side
    input  logic       pop_i,
    output lane_data_t data_o,
    // Status
    output logic       full_o,
    output logic       empty_o,
    output logic       almost_full_o,
    output fifo_cnt_t  usage_o
);

    // Storage array, payload only
    lane_data_t mem_q [FIFO_DEPTH];

    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    fifo_cnt_t cnt_q;

    logic do_push;
    logic do_pop;

    // Status flags from the usage count
    assign full_o        = (cnt_q == fifo_cnt_t'(FIFO_DEPTH));
    assign empty_o       = (cnt_q == '0);
    // Leaves room for one read already in flight
    assign almost_full_o = (cnt_q >= fifo_cnt_t'(FIFO_DEPTH - 1));
    assign usage_o       = cnt_q;

    // Overflow and underflow requests are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Head comes straight out of the register array, no bypass from data_i
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Pointers and count, flush behaves like reset
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            // Pointers wrap on their own since depth is a power of two
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb_stream_top.sv
// Operand streamer testbench
`default_nettype none

module tb_stream_top import stream_pkg::*; import wb_regs_pkg::*; ();

    // Bus ack wait per access, in cycles
    localparam int ACK_LIMIT = 8;
    // Roughly four times the summed length of all tests
    localparam int TIMEOUT_CYCLES = 2000;

    logic                clk_i;
    logic                reset_i;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    wb_addr_t            wb_adr_i;
    wb_data_t            wb_dat_i;
    logic [WB_SEL_W-1:0] wb_sel_i;
    wb_data_t            wb_dat_o;
    logic                wb_ack_o;
    logic                out_valid_o;
    merged_data_t        out_data_o;
    logic                out_ready_i;

    // Mirror of the lane memories
    lane_data_t ref_mem [NUM_LANES][MEM_DEPTH];
    // Stream model state
    mem_addr_t  tb_bound;
    mem_addr_t  exp_addr;

    integer seed = 32'hba57;
    int     errors = 0;
    int     checks = 0;
    int     access_cnt = 0;
    int     ack_cnt = 0;
    int     cycles = 0;

    stream_top dut_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

    always #2 clk_i = ~clk_i;

    // One sample per falling edge counts every cycle that ack is high
    always @(negedge clk_i) begin
        if (wb_ack_o) begin
            ack_cnt++;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_data(input string name, input merged_data_t exp,
                              input merged_data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bus(input string name, input wb_data_t exp, input wb_data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // One classic bus access holding the request until the ack cycle has closed
    task automatic bus_cycle(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = addr;
        wb_dat_i = wdata;
        wb_sel_i = '1;
        access_cnt++;
        @(negedge clk_i);
        while (!wb_ack_o && waited < ACK_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (wb_ack_o) begin
            rdata = wb_dat_o;
        end else begin
            errors++;
            $display("No ack from the bus slave for address %h", addr);
        end
        // Write lands on the edge that ends the ack cycle
        @(negedge clk_i);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t ignored;
        bus_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    // Merged word for one memory address with lane 0 low
    function automatic merged_data_t expected_word(input mem_addr_t a);
        merged_data_t w;
        w = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            w[l*LANE_DATA_W +: LANE_DATA_W] = ref_mem[l][a];
        end
        return w;
    endfunction

    // Read address wraps to zero after the inclusive bound
    function automatic mem_addr_t next_addr(input mem_addr_t a);
        return (a == tb_bound) ? mem_addr_t'(0) : mem_addr_t'(a + 1'b1);
    endfunction

    task automatic load_memories();
        logic [31:0] rnd;
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int w = 0; w < MEM_DEPTH; w++) begin
                rnd = $random(seed);
                ref_mem[l][w] = rnd[LANE_DATA_W-1:0];
                wb_write(wb_addr_t'(MEM_WINDOW_BASE | (l << WIN_LANE_LSB) | w), rnd);
            end
        end
    endtask

    // Take count words off the stream and compare with the model
    task automatic collect_words(input string name, input int count, input logic random_ready);
        int          got;
        int          waited;
        logic [31:0] rnd;
        logic        ready;
        got = 0;
        waited = 0;
        while (got < count && waited < count * 10 + 20) begin
            @(negedge clk_i);
            waited++;
            rnd = $random(seed);
            ready = random_ready ? rnd[0] : 1'b1;
            out_ready_i = ready;
            // Transfer happens on the next rising edge
            if (out_valid_o && ready) begin
                check_data(name, expected_word(exp_addr), out_data_o);
                exp_addr = next_addr(exp_addr);
                got++;
            end
        end
        @(negedge clk_i);
        out_ready_i = 1'b0;
        if (got < count) begin
            errors++;
            $display("Stream stalled in %s after %0d of %0d words", name, got, count);
        end
    endtask

    // Empty the merger stage once lanes are disabled and expect silence after
    task automatic drain_stream(input string name);
        int stuck;
        stuck = 0;
        repeat (6) begin
            @(negedge clk_i);
            out_ready_i = 1'b1;
            if (out_valid_o) begin
                check_data(name, expected_word(exp_addr), out_data_o);
                exp_addr = next_addr(exp_addr);
            end
        end
        @(negedge clk_i);
        out_ready_i = 1'b0;
        repeat (4) begin
            if (out_valid_o) begin
                stuck++;
            end
            @(negedge clk_i);
        end
        if (stuck != 0) begin
            errors++;
            $display("out_valid_o stayed high in %s after the stream was disabled", name);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s finished with %0d errors", name, errors - errs_before);
    endtask

    task automatic register_access();
        int       errs;
        wb_data_t rd;
        errs = errors;
        // Only the low four bits of the bound are kept
        wb_write(REG_BOUND, 32'h0000_00a5);
        wb_read(REG_BOUND, rd);
        check_bus("register_access bound", 32'h5, rd);
        wb_write(REG_CTRL, 32'h2);
        wb_read(REG_CTRL, rd);
        check_bus("register_access flush", 32'h0, rd);
        // Low address bits match the bound register
        wb_write(8'h21, 32'hffff_ffff);
        wb_read(REG_BOUND, rd);
        check_bus("register_access unmapped write", 32'h5, rd);
        wb_read(8'h21, rd);
        check_bus("register_access unmapped read", 32'h0, rd);
        wb_read(wb_addr_t'(MEM_WINDOW_BASE + 8'h13), rd);
        check_bus("register_access window", 32'h0, rd);
        check_bus("register_access acks", wb_data_t'(access_cnt), wb_data_t'(ack_cnt));
        report_test("register_access", errs);
    endtask

    task automatic wrapping_stream();
        int       errs;
        wb_data_t rd;
        errs = errors;
        wb_write(REG_BOUND, 32'h5);
        tb_bound = 4'd5;
        exp_addr = '0;
        wb_write(REG_CTRL, 32'h1);
        wb_read(REG_CTRL, rd);
        check_bus("wrapping_stream ctrl", 32'h1, rd);
        collect_words("wrapping_stream", 3 * (int'(tb_bound) + 1), 1'b0);
        report_test("wrapping_stream", errs);
    endtask

    task automatic back_pressure();
        int errs;
        errs = errors;
        collect_words("back_pressure", 3 * (int'(tb_bound) + 1), 1'b1);
        report_test("back_pressure", errs);
    endtask

    task automatic flush_mid_stream();
        int errs;
        errs = errors;
        // Pause and empty the merger so the flush leaves nothing stale behind
        wb_write(REG_CTRL, 32'h0);
        drain_stream("flush_mid_stream drain");
        wb_write(REG_BOUND, 32'h3);
        tb_bound = 4'd3;
        // Enabled lanes offer their buffered head during the flush cycle
        wb_write(REG_CTRL, 32'h2);
        wb_write(REG_CTRL, 32'h1);
        exp_addr = '0;
        collect_words("flush_mid_stream", 2 * (int'(tb_bound) + 1), 1'b0);
        report_test("flush_mid_stream", errs);
    endtask

    task automatic disable_resume();
        int errs;
        errs = errors;
        collect_words("disable_resume before", 5, 1'b0);
        wb_write(REG_CTRL, 32'h0);
        drain_stream("disable_resume drain");
        // Buffered words are still held and come out first
        wb_write(REG_CTRL, 32'h1);
        collect_words("disable_resume after", 2 * (int'(tb_bound) + 1), 1'b1);
        report_test("disable_resume", errs);
    endtask

    initial begin
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = '0;
        out_ready_i = 1'b0;
        tb_bound    = '0;
        exp_addr    = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        load_memories();
        register_access();
        wrapping_stream();
        back_pressure();
        flush_mid_stream();
        disable_resume();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_lane_config.sv
// Wishbone control and memory loader
`default_nettype none

module wb_lane_config import stream_pkg::*; import wb_regs_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    // Wishbone classic slave
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  wb_addr_t            wb_adr_i,
    input  wb_data_t            wb_dat_i,
    input  logic [WB_SEL_W-1:0] wb_sel_i,
    output wb_data_t            wb_dat_o,
    output logic                wb_ack_o,
    // Lane control
    output logic                stream_en_o,
    output logic                flush_o,
    output mem_addr_t           bound_o,
    // Lane memory write
    output logic                mem_we_o,
    output lane_sel_t           mem_lane_o,
    output mem_addr_t           mem_waddr_o,
    output lane_data_t          mem_wdata_o
);

    logic      ack_q;
    logic      en_q;
    logic      flush_q;
    mem_addr_t bound_q;
    wb_data_t  rdata_q;
    wb_data_t  rdata;

    logic req;
    logic commit_wr;
    logic win_hit;

    // New request only while no ack is pending
    assign req = wb_cyc_i & wb_stb_i & ~ack_q;

    // Writes commit in the ack cycle, master still holds the request there
    // Byte lanes only matter as a whole
    assign commit_wr = ack_q & wb_cyc_i & wb_stb_i & wb_we_i & (|wb_sel_i);

    assign win_hit = ((wb_adr_i & MEM_WINDOW_MASK) == MEM_WINDOW_BASE);

    // Read mux, window and holes read back as zero
    always_comb begin
        rdata = '0;
        if (wb_adr_i == REG_CTRL) begin
            // Flush bit always reads 0
            rdata[CTRL_EN_BIT] = en_q;
        end else if (wb_adr_i == REG_BOUND) begin
            rdata[MEM_ADDR_W-1:0] = bound_q;
        end
    end

    // Single cycle ack
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Read data captured with the request
    always_ff @(posedge clk_i) begin
        if (req) begin
            rdata_q <= rdata;
        end
    end

    // Control and bound registers
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            en_q    <= 1'b0;
            flush_q <= 1'b0;
            bound_q <= '0;
        end else begin
            // Flush only lasts one cycle
            flush_q <= commit_wr & (wb_adr_i == REG_CTRL) & wb_dat_i[CTRL_FLUSH_BIT];
            if (commit_wr && (wb_adr_i == REG_CTRL)) begin
                en_q <= wb_dat_i[CTRL_EN_BIT];
            end
            if (commit_wr && (wb_adr_i == REG_BOUND)) begin
                bound_q <= wb_dat_i[MEM_ADDR_W-1:0];
            end
        end
    end

    assign wb_ack_o    = ack_q;
    assign wb_dat_o    = rdata_q;
    assign stream_en_o = en_q;
    assign flush_o     = flush_q;
    assign bound_o     = bound_q;

    // Memory window write goes straight to the selected lane
    assign mem_we_o    = commit_wr & win_hit;
    assign mem_lane_o  = wb_adr_i[WIN_LANE_LSB +: LANE_SEL_W];
    assign mem_waddr_o = wb_adr_i[WIN_WORD_LSB +: MEM_ADDR_W];
    assign mem_wdata_o = wb_dat_i[LANE_DATA_W-1:0];

endmodule

`default_nettype wire

//--- wb_regs_pkg.sv
// Wishbone register map
`default_nettype none

package wb_regs_pkg;

    // Bus geometry, word addressed
    localparam int WB_ADDR_W = 8;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = WB_DATA_W / 8;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // Control and bound registers
    localparam wb_addr_t REG_CTRL  = 8'h00;
    localparam wb_addr_t REG_BOUND = 8'h01;

    // Control bits, flush is write-only and self clearing
    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_FLUSH_BIT = 1;

    // Lane memory window at 0x40..0x7f
    localparam wb_addr_t MEM_WINDOW_BASE = 8'h40;
    localparam wb_addr_t MEM_WINDOW_MASK = 8'hc0;
    // Field positions inside a window address
    localparam int WIN_LANE_LSB = 4;
    localparam int WIN_WORD_LSB = 0;

endpackage

`default_nettype wire
